//--- rtl/pbus_consts.svh
// widths, address map and register offsets of the peripheral bus; include in every RTL file
`ifndef PBUS_CONSTS_SVH
`define PBUS_CONSTS_SVH

// bus widths
`define PBUS_DATA_W         32          // wishbone data
`define PBUS_ADDR_W         32          // wishbone address
`define PBUS_SEL_W          4           // one select per byte

// address decode
`define PBUS_NUM_SLV        4           // gpio_out, gpio_in, tim0, tim1
`define PBUS_SLV_LSB        12          // slave field
`define PBUS_SLV_MSB        15
`define PBUS_OFS_LSB        2           // word offset inside a slave
`define PBUS_OFS_MSB        3

// pins and interrupts
`define PBUS_NUM_GPIO_IN    8
`define PBUS_NUM_GPIO_OUT   8
`define PBUS_NUM_IRQ        3           // {tim1, tim0, gpio_in}

// register word offsets
`define PBUS_TIM_CTRL       2'd0
`define PBUS_TIM_LOAD       2'd1
`define PBUS_TIM_COUNT      2'd2        // read only
`define PBUS_TIM_STATUS     2'd3        // bit 0 expired, write 1 to clear
`define PBUS_GIN_DATA       2'd0        // read only
`define PBUS_GIN_IRQ_EN     2'd1
`define PBUS_GIN_STATUS     2'd2        // bit 0 changed, write 1 to clear
`define PBUS_GOUT_DATA      2'd0

`endif

//--- rtl/pbus_bus_pkg.sv
// bus-side types: the wishbone slave port and the request fanned out to every peripheral
`include "pbus_consts.svh"

package pbus_bus_pkg;

    ////////////////////
    // wishbone port
    ////////////////////

    // master to bus, held stable until ack or err
    typedef struct packed {
        logic                       cyc;    // bus cycle in progress
        logic                       stb;    // access strobe
        logic                       we;     // 1 write, 0 read
        logic [`PBUS_ADDR_W-1:0]    adr;    // byte address
        logic [`PBUS_DATA_W-1:0]    dat;    // write data
        logic [`PBUS_SEL_W-1:0]     sel;    // byte selects
    } wb_req_t;

    // bus to master
    typedef struct packed {
        logic                       ack;    // normal termination
        logic                       err;    // unmapped address
        logic [`PBUS_DATA_W-1:0]    dat;    // read data, valid with ack
    } wb_rsp_t;

    ////////////////////
    // internal slave side
    ////////////////////

    // shared by all slaves, strobes travel apart
    typedef struct packed {
        logic                                   we;     // write access
        logic [`PBUS_OFS_MSB-`PBUS_OFS_LSB:0]   ofs;    // register word offset
        logic [`PBUS_DATA_W-1:0]                dat;    // write data
        logic [`PBUS_SEL_W-1:0]                 sel;    // byte selects
    } slv_req_t;

endpackage : pbus_bus_pkg

//--- rtl/pbus_periph_pkg.sv
// peripheral-side types: timer control word layout and the packed read data of all slaves
`include "pbus_consts.svh"

package pbus_periph_pkg;

    ////////////////////
    // timer
    ////////////////////

    // CTRL register, upper bits read as zero
    typedef struct packed {
        logic [`PBUS_DATA_W-4:0]    rsvd;           // padding to bus width
        logic                       irq_en;         // bit 2, expired drives irq
        logic                       auto_reload;    // bit 1, reload from LOAD at zero
        logic                       enable;         // bit 0, count running
    } tim_ctrl_t;

    ////////////////////
    // read data return
    ////////////////////

    // index 0 gpio_out, 1 gpio_in, 2 tim0, 3 tim1
    typedef logic [`PBUS_NUM_SLV-1:0][`PBUS_DATA_W-1:0] slv_rdata_t;

endpackage : pbus_periph_pkg

//--- rtl/pbus_cycle_fsm.sv
// wishbone classic cycle FSM; decodes the slave field, strobes one slave and returns ack or err
`timescale 1ns/1ps
`include "pbus_consts.svh"

module pbus_cycle_fsm (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  pbus_bus_pkg::wb_req_t           wb_req_i,       // from master
    input  pbus_periph_pkg::slv_rdata_t     slv_rdata_i,    // all slaves, by index
    output pbus_bus_pkg::wb_rsp_t           wb_rsp_o,
    output pbus_bus_pkg::slv_req_t          slv_req_o,      // shared request
    output logic [`PBUS_NUM_SLV-1:0]        slv_stb_o       // one-hot, one cycle
);

    localparam int unsigned IDX_W = $clog2(`PBUS_NUM_SLV);

    typedef enum logic [1:0] {IDLE, ACCESS, RESP} state_t;

    state_t                                 state_q;
    logic                                   stb_wait_q;     // answered, wait for stb low
    logic                                   err_q;          // unmapped slave field
    logic [IDX_W-1:0]                       idx_q;          // selected slave
    logic [`PBUS_DATA_W-1:0]                rdata_q;        // captured read data
    pbus_bus_pkg::slv_req_t                 req_q;          // registered request
    logic [`PBUS_SLV_MSB-`PBUS_SLV_LSB:0]   slv_field;
    logic                                   new_access;

    assign slv_field  = wb_req_i.adr[`PBUS_SLV_MSB:`PBUS_SLV_LSB];
    assign new_access = wb_req_i.cyc & wb_req_i.stb & ~stb_wait_q;

    ////////////////////
    // state and decode
    ////////////////////
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            stb_wait_q <= 1'b0;
            err_q      <= 1'b0;
            idx_q      <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!wb_req_i.stb) stb_wait_q <= 1'b0;              // master let go
                    if (new_access) begin
                        state_q <= ACCESS;
                        err_q   <= (slv_field >= `PBUS_NUM_SLV);        // fields 4..15 unmapped
                        idx_q   <= slv_field[IDX_W-1:0];
                    end
                end
                ACCESS:  state_q <= RESP;                               // slave hit this cycle
                RESP: begin
                    state_q    <= IDLE;
                    stb_wait_q <= 1'b1;                                 // no re-accept on held stb
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    ////////////////////
    // request and read data
    ////////////////////
    always_ff @(posedge clock_i) begin
        if (state_q == IDLE && new_access) begin
            req_q.we  <= wb_req_i.we;
            req_q.ofs <= wb_req_i.adr[`PBUS_OFS_MSB:`PBUS_OFS_LSB];
            req_q.dat <= wb_req_i.dat;
            req_q.sel <= wb_req_i.sel;
        end
        if (state_q == ACCESS) rdata_q <= err_q ? '0 : slv_rdata_i[idx_q];   // zero on err
    end

    assign slv_req_o = req_q;
    assign slv_stb_o = (state_q == ACCESS && !err_q) ? (`PBUS_NUM_SLV'(1) << idx_q) : '0;
    assign wb_rsp_o  = '{ack: (state_q == RESP) & ~err_q,
                         err: (state_q == RESP) &  err_q,
                         dat: rdata_q};

endmodule : pbus_cycle_fsm

//--- rtl/pbus_timer.sv
// down-counting timer with CTRL, LOAD, COUNT and STATUS registers; used for tim0 and tim1
`timescale 1ns/1ps
`include "pbus_consts.svh"

module pbus_timer (
    input  logic                        clock_i,
    input  logic                        rst_i,
    input  logic                        stb_i,      // this slave selected
    input  pbus_bus_pkg::slv_req_t      req_i,
    output logic [`PBUS_DATA_W-1:0]     rdata_o,
    output logic                        irq_o
);

    pbus_periph_pkg::tim_ctrl_t     ctrl_q;
    pbus_periph_pkg::tim_ctrl_t     wr_ctrl;        // write data seen as CTRL
    logic [`PBUS_DATA_W-1:0]        load_q;
    logic [`PBUS_DATA_W-1:0]        count_q;
    logic [`PBUS_DATA_W-1:0]        load_nxt;       // LOAD after byte merge
    logic                           expired_q;
    logic                           wr_en;
    logic                           tick_zero;      // enabled and at zero

    assign wr_en     = stb_i & req_i.we;
    assign wr_ctrl   = req_i.dat;
    assign tick_zero = ctrl_q.enable & (count_q == '0);

    // byte-wise merge for LOAD
    always_comb begin
        load_nxt = load_q;
        for (int b = 0; b < `PBUS_SEL_W; b++) begin
            if (req_i.sel[b]) load_nxt[8*b +: 8] = req_i.dat[8*b +: 8];
        end
    end

    ////////////////////
    // count and registers
    ////////////////////
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            ctrl_q    <= '0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
        end else begin
            if (tick_zero) begin
                if (ctrl_q.auto_reload) count_q <= load_q;      // periodic
                else                    ctrl_q.enable <= 1'b0;  // one-shot stops
            end else if (ctrl_q.enable) begin
                count_q <= count_q - 1'b1;
            end
            if (wr_en) begin                                    // bus write wins over count
                case (req_i.ofs)
                    `PBUS_TIM_CTRL: if (req_i.sel[0]) begin
                        ctrl_q.enable      <= wr_ctrl.enable;
                        ctrl_q.auto_reload <= wr_ctrl.auto_reload;
                        ctrl_q.irq_en      <= wr_ctrl.irq_en;
                    end
                    `PBUS_TIM_LOAD: begin
                        load_q  <= load_nxt;
                        count_q <= load_nxt;                    // restart from new value
                    end
                    `PBUS_TIM_STATUS: if (req_i.sel[0] && req_i.dat[0]) expired_q <= 1'b0;
                    default: ;                                  // COUNT read only
                endcase
            end
            if (tick_zero) expired_q <= 1'b1;                   // set beats clear
        end
    end

    // read mux
    always_comb begin
        case (req_i.ofs)
            `PBUS_TIM_CTRL:  rdata_o = ctrl_q;
            `PBUS_TIM_LOAD:  rdata_o = load_q;
            `PBUS_TIM_COUNT: rdata_o = count_q;
            default:         rdata_o = `PBUS_DATA_W'(expired_q);  // STATUS
        endcase
    end

    assign irq_o = expired_q & ctrl_q.irq_en;

endmodule : pbus_timer

//--- rtl/pbus_gpio_out.sv
// GPIO output block; one data register driving the output pins, written through the bus
`timescale 1ns/1ps
`include "pbus_consts.svh"

module pbus_gpio_out (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  logic                            stb_i,      // this slave selected
    input  pbus_bus_pkg::slv_req_t          req_i,
    output logic [`PBUS_DATA_W-1:0]         rdata_o,
    output logic [`PBUS_NUM_GPIO_OUT-1:0]   gpio_out_o
);

    logic [`PBUS_NUM_GPIO_OUT-1:0]  data_q;     // pin state
    logic                           data_sel;   // DATA addressed

    assign data_sel = (req_i.ofs == `PBUS_GOUT_DATA);

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            data_q <= '0;                       // pins low out of reset
        end else if (stb_i && req_i.we && data_sel && req_i.sel[0]) begin
            data_q <= req_i.dat[`PBUS_NUM_GPIO_OUT-1:0];
        end
    end

    assign rdata_o    = data_sel ? `PBUS_DATA_W'(data_q) : '0;   // other offsets read zero
    assign gpio_out_o = data_q;

endmodule : pbus_gpio_out

//--- rtl/pbus_gpio_in.sv
// GPIO input block; synchronizes the pins and raises an interrupt on any change
`timescale 1ns/1ps
`include "pbus_consts.svh"

module pbus_gpio_in (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  logic                            stb_i,      // this slave selected
    input  pbus_bus_pkg::slv_req_t          req_i,
    input  logic [`PBUS_NUM_GPIO_IN-1:0]    gpio_in_i,  // asynchronous pins
    output logic [`PBUS_DATA_W-1:0]         rdata_o,
    output logic                            irq_o
);

    logic [`PBUS_NUM_GPIO_IN-1:0]   sync1_q;    // first stage, may go metastable
    logic [`PBUS_NUM_GPIO_IN-1:0]   sync2_q;    // DATA register
    logic [`PBUS_NUM_GPIO_IN-1:0]   prev_q;     // DATA one cycle ago
    logic                           irq_en_q;
    logic                           status_q;   // change seen
    logic                           wr_en;

    assign wr_en = stb_i & req_i.we & req_i.sel[0];

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
            irq_en_q <= 1'b0;
            status_q <= 1'b0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (wr_en && req_i.ofs == `PBUS_GIN_IRQ_EN) irq_en_q <= req_i.dat[0];
            if (wr_en && req_i.ofs == `PBUS_GIN_STATUS && req_i.dat[0]) status_q <= 1'b0;
            if (sync2_q != prev_q) status_q <= 1'b1;        // new change beats clear
        end
    end

    // read mux
    always_comb begin
        case (req_i.ofs)
            `PBUS_GIN_DATA:   rdata_o = `PBUS_DATA_W'(sync2_q);
            `PBUS_GIN_IRQ_EN: rdata_o = `PBUS_DATA_W'(irq_en_q);
            `PBUS_GIN_STATUS: rdata_o = `PBUS_DATA_W'(status_q);
            default:          rdata_o = '0;                 // unused offset
        endcase
    end

    assign irq_o = status_q & irq_en_q;

endmodule : pbus_gpio_in

//--- rtl/peripheral_bus.sv
// peripheral bus top level; one wishbone slave port in front of gpio_out, gpio_in, tim0 and tim1
`timescale 1ns/1ps
`include "pbus_consts.svh"

module peripheral_bus (
    input  logic                            clock_i,
    input  logic                            rst_i,
    input  pbus_bus_pkg::wb_req_t           wb_req_i,
    output pbus_bus_pkg::wb_rsp_t           wb_rsp_o,
    input  logic [`PBUS_NUM_GPIO_IN-1:0]    gpio_in_i,
    output logic [`PBUS_NUM_GPIO_OUT-1:0]   gpio_out_o,
    output logic [`PBUS_NUM_IRQ-1:0]        int_o
);

    ////////////////////
    // internal bus
    ////////////////////
    pbus_bus_pkg::slv_req_t         slv_req;        // same request to all slaves
    logic [`PBUS_NUM_SLV-1:0]       slv_stb;        // one strobe per slave
    pbus_periph_pkg::slv_rdata_t    slv_rdata;      // packed by slave index
    logic                           gpio_in_int;
    logic                           tim0_int;
    logic                           tim1_int;

    assign int_o = {tim1_int, tim0_int, gpio_in_int};

    pbus_cycle_fsm cycle_fsm_u (
        .clock_i     ( clock_i   ),
        .rst_i       ( rst_i     ),
        .wb_req_i    ( wb_req_i  ),
        .slv_rdata_i ( slv_rdata ),
        .wb_rsp_o    ( wb_rsp_o  ),
        .slv_req_o   ( slv_req   ),
        .slv_stb_o   ( slv_stb   )
    );

    ////////////////////
    // slaves
    ////////////////////
    pbus_gpio_out gpio_out_u (                      // slave 0
        .clock_i ( clock_i ), .rst_i ( rst_i ), .stb_i ( slv_stb[0] ), .req_i ( slv_req ),
        .rdata_o ( slv_rdata[0] ), .gpio_out_o ( gpio_out_o )
    );

    pbus_gpio_in gpio_in_u (                        // slave 1
        .clock_i ( clock_i ), .rst_i ( rst_i ), .stb_i ( slv_stb[1] ), .req_i ( slv_req ),
        .gpio_in_i ( gpio_in_i ), .rdata_o ( slv_rdata[1] ), .irq_o ( gpio_in_int )
    );

    pbus_timer tim0_u (                             // slave 2
        .clock_i ( clock_i ), .rst_i ( rst_i ), .stb_i ( slv_stb[2] ), .req_i ( slv_req ),
        .rdata_o ( slv_rdata[2] ), .irq_o ( tim0_int )
    );

    pbus_timer tim1_u (                             // slave 3
        .clock_i ( clock_i ), .rst_i ( rst_i ), .stb_i ( slv_stb[3] ), .req_i ( slv_req ),
        .rdata_o ( slv_rdata[3] ), .irq_o ( tim1_int )
    );

endmodule : peripheral_bus

//--- testbench/tb_peripheral_bus.sv
// testbench of the peripheral bus; runs wishbone accesses and checks them against a shadow model
`timescale 1ns/1ps
`include "pbus_consts.svh"

module tb_peripheral_bus;

    localparam int unsigned NUM_ACC  = 120;     // upper bound on bus accesses
    localparam int unsigned TIM0_MAX = 16;      // largest tim0 load
    localparam int unsigned TIM1_MAX = 12;      // largest tim1 load, three periods run
    localparam int unsigned LIMIT    = NUM_ACC * 6 + 2 * (TIM0_MAX + 3 * TIM1_MAX) + 200;

    logic                               clock_i = 1'b0;
    logic                               rst_i;
    pbus_bus_pkg::wb_req_t              wb_req;
    pbus_bus_pkg::wb_rsp_t              wb_rsp;
    logic [`PBUS_NUM_GPIO_IN-1:0]       gpio_in;
    logic [`PBUS_NUM_GPIO_OUT-1:0]      gpio_out;
    logic [`PBUS_NUM_IRQ-1:0]           irq;
    logic [31:0]                        lcg_state = 32'hf8d1;
    logic [`PBUS_DATA_W-1:0]            shadow [`PBUS_NUM_SLV][4];     // [slave][offset]
    logic [`PBUS_DATA_W-1:0]            exp_dat;
    logic                               exp_err;
    logic                               chk_dat;
    logic                               pending = 1'b0;                 // access accepted
    int unsigned                        cycles = 0;
    int unsigned                        accept_edge;

    peripheral_bus i_dut (
        .clock_i ( clock_i ), .rst_i ( rst_i ), .wb_req_i ( wb_req ), .wb_rsp_o ( wb_rsp ),
        .gpio_in_i ( gpio_in ), .gpio_out_o ( gpio_out ), .int_o ( irq )
    );

    always #50 clock_i = ~clock_i;              // 100 ns period

    task automatic report_fail(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////
    // reference model
    ////////////////////
    function automatic void update_shadow(input int slv, input logic [1:0] ofs,
                                          input logic [31:0] dat, input logic [3:0] sel);
        if (slv == 0 && ofs == `PBUS_GOUT_DATA && sel[0]) shadow[0][ofs] = dat;
        if (slv == 1 && ofs == `PBUS_GIN_IRQ_EN && sel[0]) shadow[1][ofs] = dat;
        if (slv == 1 && ofs == `PBUS_GIN_STATUS && sel[0] && dat[0]) shadow[1][ofs] = '0;
        if (slv == 2 || slv == 3) begin
            if (ofs == `PBUS_TIM_CTRL && sel[0]) shadow[slv][ofs] = dat;
            if (ofs == `PBUS_TIM_STATUS && sel[0] && dat[0]) shadow[slv][ofs] = '0;   // w1c
            if (ofs == `PBUS_TIM_LOAD) begin
                for (int b = 0; b < `PBUS_SEL_W; b++)
                    if (sel[b]) shadow[slv][ofs][8*b +: 8] = dat[8*b +: 8];
                shadow[slv][`PBUS_TIM_COUNT] = shadow[slv][ofs];     // load restarts count
            end
        end
    endfunction

    function automatic logic [31:0] expected_read(input int slv, input logic [1:0] ofs);
        logic [31:0] val;
        val = '0;
        case (slv)
            0: if (ofs == `PBUS_GOUT_DATA) val = shadow[0][ofs] & 32'hff;  // pins only
            1: begin
                if (ofs == `PBUS_GIN_DATA) val = shadow[1][ofs] & 32'hff;
                else if (ofs != 2'd3) val = shadow[1][ofs] & 32'h1;        // irq_en, status
            end
            2, 3: begin
                if (ofs == `PBUS_TIM_CTRL) val = shadow[slv][ofs] & 32'h7;
                else if (ofs == `PBUS_TIM_STATUS) val = shadow[slv][ofs] & 32'h1;
                else val = shadow[slv][ofs];
            end
            default: val = '0;                  // unmapped
        endcase
        return val;
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////
    task automatic bus_cycle(input int slv, input logic [1:0] ofs, input logic we,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] rdat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, dat: dat, sel: sel,
                   adr: (32'(slv) << `PBUS_SLV_LSB) | (32'(ofs) << `PBUS_OFS_LSB)};
        do @(posedge clock_i); while (!(wb_rsp.ack || wb_rsp.err));   // timeout bounds this
        rdat = wb_rsp.dat;
        #10 wb_req = '0;                        // stb low for a cycle
        @(posedge clock_i);
        #10;
    endtask

    task automatic wb_write(input int slv, input logic [1:0] ofs, input logic [31:0] dat,
                            input logic [3:0] sel);
        logic [31:0] unused;
        exp_err = (slv >= `PBUS_NUM_SLV);
        chk_dat = 1'b0;
        bus_cycle(slv, ofs, 1'b1, dat, sel, unused);
        if (slv < `PBUS_NUM_SLV) update_shadow(slv, ofs, dat, sel);
    endtask

    task automatic wb_read(input int slv, input logic [1:0] ofs, input logic check,
                           output logic [31:0] rdat);
        exp_err = (slv >= `PBUS_NUM_SLV);
        chk_dat = check && !exp_err;
        exp_dat = expected_read(slv, ofs);
        bus_cycle(slv, ofs, 1'b0, 32'h0, 4'hf, rdat);
    endtask

    ////////////////////
    // compare and timeout
    ////////////////////
    always @(posedge clock_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("the run timed out after %0d cycles before all tests finished", cycles);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end else if (!rst_i) begin
            if (wb_rsp.ack || wb_rsp.err) begin
                assert (pending && cycles == accept_edge + 2)
                    else report_fail("response not two edges after the accepting edge");
                assert (wb_rsp.err == exp_err && wb_rsp.ack == !exp_err)
                    else report_fail($sformatf("ack %0b err %0b, err expected %0b",
                                               wb_rsp.ack, wb_rsp.err, exp_err));
                assert (!chk_dat || wb_rsp.dat == exp_dat)
                    else report_fail($sformatf("read 0x%08h, expected 0x%08h",
                                               wb_rsp.dat, exp_dat));
                pending = 1'b0;
            end else if (wb_req.cyc && wb_req.stb && !pending) begin
                pending     = 1'b1;             // edge T
                accept_edge = cycles;
            end
        end
    end

    task automatic read_all_regs();
        logic [31:0] rd;
        for (int s = 0; s < `PBUS_NUM_SLV; s++)
            for (int o = 0; o < 4; o++) wb_read(s, o[1:0], 1'b1, rd);
    endtask

    ////////////////////
    // tests
    ////////////////////
    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        int unsigned ld0;
        int unsigned ld1;
        wb_req  = '0;
        gpio_in = '0;
        rst_i   = 1'b1;
        for (int s = 0; s < `PBUS_NUM_SLV; s++)
            for (int o = 0; o < 4; o++) shadow[s][o] = '0;
        repeat (5) @(posedge clock_i);
        #10 rst_i = 1'b0;
        assert (!wb_rsp.ack && !wb_rsp.err && gpio_out == '0 && irq == '0)
            else report_fail("outputs not zero after reset");
        read_all_regs();

        // gpio output, then a write without byte 0
        rnd = next_random();
        wb_write(0, `PBUS_GOUT_DATA, rnd, 4'hf);
        assert (gpio_out == rnd[7:0]) else report_fail("gpio_out_o differs from written data");
        wb_read(0, `PBUS_GOUT_DATA, 1'b1, rd);
        wb_write(0, `PBUS_GOUT_DATA, next_random(), 4'b1110);
        wb_read(0, `PBUS_GOUT_DATA, 1'b1, rd);
        assert (gpio_out == rnd[7:0]) else report_fail("gpio_out_o changed without sel bit 0");

        // gpio input change and its interrupt
        rnd     = next_random();
        gpio_in = rnd[7:0] | 8'h01;             // differs from the reset value
        shadow[1][`PBUS_GIN_DATA]   = {24'h0, gpio_in};
        shadow[1][`PBUS_GIN_STATUS] = 32'h1;
        repeat (4) @(posedge clock_i);
        #10;
        wb_read(1, `PBUS_GIN_DATA, 1'b1, rd);
        wb_read(1, `PBUS_GIN_STATUS, 1'b1, rd);
        assert (irq == 3'b000) else report_fail("int_o bit 0 high before irq_en was set");
        wb_write(1, `PBUS_GIN_IRQ_EN, 32'h1, 4'hf);
        assert (irq == 3'b001) else report_fail("int_o bit 0 not raised by gpio_in change");
        wb_write(1, `PBUS_GIN_STATUS, 32'h1, 4'hf);
        assert (irq == 3'b000) else report_fail("int_o bit 0 still high after status clear");

        // tim0 one-shot
        ld0 = 2 + next_random() % (TIM0_MAX - 2);
        wb_write(2, `PBUS_TIM_LOAD, ld0, 4'hf);
        wb_read(2, `PBUS_TIM_COUNT, 1'b1, rd);
        wb_write(2, `PBUS_TIM_CTRL, 32'h5, 4'h1);                 // enable, irq_en
        do wb_read(2, `PBUS_TIM_STATUS, 1'b0, rd); while (!rd[0]);
        shadow[2][`PBUS_TIM_STATUS]  = 32'h1;
        shadow[2][`PBUS_TIM_COUNT]   = '0;
        shadow[2][`PBUS_TIM_CTRL][0] = 1'b0;                      // one-shot stops
        assert (irq == 3'b010) else report_fail("int_o bit 1 not raised by tim0 expiry");
        wb_read(2, `PBUS_TIM_COUNT, 1'b1, rd);
        wb_read(2, `PBUS_TIM_CTRL, 1'b1, rd);
        wb_write(2, `PBUS_TIM_STATUS, 32'h1, 4'h1);
        assert (irq == 3'b000) else report_fail("int_o bit 1 still high after status clear");

        // tim1 auto-reload, three expiries
        ld1 = 3 + next_random() % (TIM1_MAX - 4);
        wb_write(3, `PBUS_TIM_LOAD, ld1, 4'hf);
        wb_write(3, `PBUS_TIM_CTRL, 32'h3, 4'h1);                 // enable, auto_reload
        repeat (3) begin
            wb_write(3, `PBUS_TIM_STATUS, 32'h1, 4'h1);
            do begin
                wb_read(3, `PBUS_TIM_COUNT, 1'b0, rd);
                assert (rd <= ld1) else report_fail($sformatf("tim1 COUNT %0d above LOAD %0d",
                                                              rd, ld1));
                wb_read(3, `PBUS_TIM_STATUS, 1'b0, rd);
            end while (!rd[0]);
        end
        wb_write(3, `PBUS_TIM_CTRL, 32'h7, 4'h1);                 // irq_en on, expired still set
        assert (irq == 3'b100) else report_fail("int_o bit 2 not raised by tim1 expiry");
        wb_write(3, `PBUS_TIM_CTRL, 32'h0, 4'h1);                 // stop, then known state
        wb_write(3, `PBUS_TIM_LOAD, ld1, 4'hf);
        wb_write(3, `PBUS_TIM_STATUS, 32'h1, 4'h1);

        // unmapped slave field
        wb_write(5, `PBUS_GIN_IRQ_EN, next_random() & 32'hffff_fffe, 4'hf);  // irq_en is 1
        wb_read(5, 2'd1, 1'b1, rd);
        read_all_regs();                                          // nothing changed
        assert (irq == 3'b000) else report_fail("int_o not zero at the end");

        $display("Test OK");
        $finish;
    end

endmodule : tb_peripheral_bus

//--- list.f
+incdir+rtl
rtl/pbus_bus_pkg.sv
rtl/pbus_periph_pkg.sv
rtl/pbus_cycle_fsm.sv
rtl/pbus_timer.sv
rtl/pbus_gpio_out.sv
rtl/pbus_gpio_in.sv
rtl/peripheral_bus.sv
testbench/tb_peripheral_bus.sv
